// ==== verilog/csr_pkg.sv ====
package csr_pkg;

    // Data path widths
    localparam int XLEN       = 32;
    localparam int CNT_W      = 64;
    localparam int CSR_ADDR_W = 12;
    localparam int IMM_W      = 5;  // zimm field of the immediate forms

    typedef logic [XLEN-1:0]       xlen_t;      // Register word, operand and read data
    typedef logic [CNT_W-1:0]      cnt_t;       // One full counter
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // User read-only shadows
    localparam csr_addr_t ADDR_CYCLE    = 12'hC00;
    localparam csr_addr_t ADDR_CYCLEH   = 12'hC80;
    localparam csr_addr_t ADDR_TIME     = 12'hC01;
    localparam csr_addr_t ADDR_TIMEH    = 12'hC81;
    localparam csr_addr_t ADDR_INSTRET  = 12'hC02;
    localparam csr_addr_t ADDR_INSTRETH = 12'hC82;
    // Machine writable views
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;

    // Time ticks once per TIME_DIV clocks
    localparam int TIME_DIV = 4;
    localparam int PRESC_W  = $clog2(TIME_DIV);

    typedef logic [PRESC_W-1:0] presc_t;

    // Zicsr op codes, 3'd7 left undefined and treated as illegal
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_RW   = 3'd1,
        OP_RS   = 3'd2,
        OP_RC   = 3'd3,
        OP_RWI  = 3'd4,
        OP_RSI  = 3'd5,
        OP_RCI  = 3'd6
    } csr_op_e;

    typedef enum logic [1:0] {
        SEL_CYCLE   = 2'd0,
        SEL_TIME    = 2'd1,
        SEL_INSTRET = 2'd2
    } cnt_sel_e;

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     wdata;  // rs1 value or zimm in the low bits
    } csr_req_t;  // 47 bits

    typedef struct packed {
        cnt_t cycle;
        cnt_t timer;
        cnt_t instret;
    } cnt_bank_t;  // 192 bits

    typedef struct packed {
        logic     en;
        cnt_sel_e sel;
        logic     hi;    // Upper word 63:32
        xlen_t    data;
    } cnt_wr_t;  // 36 bits

endpackage

// ==== verilog/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               retire_i,
    input  csr_pkg::cnt_wr_t   wr_i,
    output csr_pkg::cnt_bank_t cnt_o
);

    import csr_pkg::*;

    cnt_t   cycle_q;
    cnt_t   timer_q;
    cnt_t   instret_q;
    presc_t presc_q;   // Counts 0 .. TIME_DIV-1

    logic   tick;      // Prescaler wrap
    logic   cycle_hit;
    logic   instret_hit;

    // Next counter value, a half-word write wins over the increment
    function automatic cnt_t next_cnt(
        input cnt_t  cur,
        input logic  inc,
        input logic  hit,
        input logic  hi,
        input xlen_t data
    );
        cnt_t nxt;
        nxt = cur + cnt_t'(inc);  // Full 64-bit add, carry into upper word
        if (hit) begin
            // Untouched half keeps its old value, no increment this edge
            if (hi) begin
                nxt = {data, cur[XLEN-1:0]};
            end else begin
                nxt = {cur[CNT_W-1:XLEN], data};
            end
        end
        return nxt;
    endfunction

    assign tick        = (presc_q == presc_t'(TIME_DIV - 1));
    assign cycle_hit   = wr_i.en && (wr_i.sel == SEL_CYCLE);
    assign instret_hit = wr_i.en && (wr_i.sel == SEL_INSTRET);
    // SEL_TIME never arrives here, time is read only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q   <= '0;
            timer_q   <= '0;
            instret_q <= '0;
            presc_q   <= '0;
        end else begin
            cycle_q   <= next_cnt(cycle_q, 1'b1, cycle_hit, wr_i.hi, wr_i.data);
            instret_q <= next_cnt(instret_q, retire_i, instret_hit, wr_i.hi, wr_i.data);
            timer_q   <= timer_q + cnt_t'(tick);  // No write path on time
            if (tick) begin
                presc_q <= '0;
            end else begin
                presc_q <= presc_q + presc_t'(1);
            end
        end
    end

    // Whole bank visible to the access logic every cycle
    assign cnt_o.cycle   = cycle_q;
    assign cnt_o.timer   = timer_q;
    assign cnt_o.instret = instret_q;

endmodule

// ==== verilog/csr_access.sv ====
`timescale 1ns/1ps

module csr_access (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_req_t  req_i,
    input  csr_pkg::cnt_bank_t cnt_i,
    output csr_pkg::cnt_wr_t   wr_o,
    output csr_pkg::xlen_t     rdata_o,
    output logic               illegal_o
);

    import csr_pkg::*;

    // Address decode
    cnt_sel_e sel;
    logic     hi;        // Upper half view
    logic     ro;        // Read-only shadow
    logic     addr_ok;

    // Op decode
    logic     req_vld;   // Any op other than NONE
    logic     op_imm;    // Immediate forms use zimm
    logic     op_bad;    // Op code 7
    logic     wants_wr;  // Op would modify the CSR
    xlen_t    operand;
    xlen_t    new_val;

    cnt_t     cnt_sel;   // Selected counter
    xlen_t    old_half;  // Value returned to the core
    logic     illegal;
    logic     wr_en;

    // Result registers
    xlen_t    rdata_q;
    logic     illegal_q;

    assign req_vld = (req_i.op != OP_NONE);
    assign hi      = req_i.addr[7];  // Upper halves sit at +0x80

    always_comb begin
        sel     = SEL_CYCLE;
        ro      = 1'b1;
        addr_ok = 1'b1;
        case (req_i.addr)
            ADDR_MCYCLE, ADDR_MCYCLEH: begin
                sel = SEL_CYCLE;
                ro  = 1'b0;
            end
            ADDR_MINSTRET, ADDR_MINSTRETH: begin
                sel = SEL_INSTRET;
                ro  = 1'b0;
            end
            ADDR_CYCLE, ADDR_CYCLEH: begin
                sel = SEL_CYCLE;
            end
            ADDR_TIME, ADDR_TIMEH: begin
                sel = SEL_TIME;
            end
            ADDR_INSTRET, ADDR_INSTRETH: begin
                sel = SEL_INSTRET;
            end
            default: begin
                addr_ok = 1'b0;  // Not a counter CSR
            end
        endcase
    end

    // Old value of the addressed half
    always_comb begin
        case (sel)
            SEL_TIME:    cnt_sel = cnt_i.timer;
            SEL_INSTRET: cnt_sel = cnt_i.instret;
            default:     cnt_sel = cnt_i.cycle;
        endcase
    end

    assign old_half = hi ? cnt_sel[CNT_W-1:XLEN] : cnt_sel[XLEN-1:0];

    assign op_imm  = (req_i.op == OP_RWI) || (req_i.op == OP_RSI) || (req_i.op == OP_RCI);
    assign operand = op_imm ? xlen_t'(req_i.wdata[IMM_W-1:0]) : req_i.wdata;

    // New value and whether the op writes at all
    always_comb begin
        new_val  = old_half;
        wants_wr = 1'b0;
        op_bad   = 1'b0;
        case (req_i.op)
            OP_NONE: begin
                wants_wr = 1'b0;
            end
            OP_RW, OP_RWI: begin
                new_val  = operand;
                wants_wr = 1'b1;  // Always writes, even zero
            end
            OP_RS, OP_RSI: begin
                new_val  = old_half | operand;
                wants_wr = |operand;  // Zero mask is a pure read
            end
            OP_RC, OP_RCI: begin
                new_val  = old_half & ~operand;
                wants_wr = |operand;
            end
            default: begin
                op_bad = 1'b1;
            end
        endcase
    end

    // Unknown CSR, bad op or a write to a shadow
    assign illegal = req_vld && (!addr_ok || op_bad || (ro && wants_wr));
    assign wr_en   = req_vld && !illegal && wants_wr;

    // Same-cycle strobe to the counter bank
    assign wr_o.en   = wr_en;
    assign wr_o.sel  = sel;
    assign wr_o.hi   = hi;
    assign wr_o.data = new_val;

    // Result lands one cycle later and holds until the next request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q   <= '0;
            illegal_q <= 1'b0;
        end else if (req_vld) begin
            rdata_q   <= illegal ? '0 : old_half;  // Zero on a rejected request
            illegal_q <= illegal;
        end
    end

    assign rdata_o   = rdata_q;
    assign illegal_o = illegal_q;

endmodule

// ==== verilog/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_req_t req_i,
    input  logic              retire_i,  // One pulse per retired instruction
    output csr_pkg::xlen_t    rdata_o,
    output logic              illegal_o
);

    import csr_pkg::*;

    cnt_bank_t cnt_bank;  // Live counter values
    cnt_wr_t   cnt_wr;    // Half-word write strobe

    // Decode, write gating and registered read
    csr_access u_access (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_i),
        .cnt_i     (cnt_bank),
        .wr_o      (cnt_wr),
        .rdata_o   (rdata_o),
        .illegal_o (illegal_o)
    );

    // cycle, time and instret storage
    csr_counters u_counters (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire_i (retire_i),
        .wr_i     (cnt_wr),
        .cnt_o    (cnt_bank)
    );

endmodule

// ==== dv/csr_unit_sva.sv ====
`timescale 1ns/1ps

module csr_unit_sva (
    input logic              clk,
    input logic              rst_n,
    input csr_pkg::csr_req_t req_i,
    input csr_pkg::xlen_t    rdata_o,
    input logic              illegal_o
);

    import csr_pkg::*;

    int unsigned fail_cnt = 0;  // Read by the testbench at the end

    logic      known;     // One of the ten counter addresses
    logic      writable;  // Machine view
    logic      writes;    // Op would modify the CSR
    logic      bad;       // Request must be rejected
    xlen_t     opnd;

    // Shadow of the previous request
    logic      wr_q;      // It wrote a writable view
    logic      bad_q;     // It had to be rejected
    csr_op_e   op_q;
    csr_addr_t addr_q;
    xlen_t     opnd_q;
    logic      chk_q;     // Back-to-back read of the same CSR
    xlen_t     exp_q;

    always_comb begin
        known    = req_i.addr inside {ADDR_CYCLE, ADDR_CYCLEH, ADDR_TIME, ADDR_TIMEH,
                                      ADDR_INSTRET, ADDR_INSTRETH, ADDR_MCYCLE,
                                      ADDR_MCYCLEH, ADDR_MINSTRET, ADDR_MINSTRETH};
        writable = req_i.addr inside {ADDR_MCYCLE, ADDR_MCYCLEH, ADDR_MINSTRET, ADDR_MINSTRETH};
        opnd     = (req_i.op inside {OP_RWI, OP_RSI, OP_RCI}) ? {27'b0, req_i.wdata[4:0]}
                                                             : req_i.wdata;
        writes   = (req_i.op inside {OP_RW, OP_RWI}) ||
                   ((req_i.op inside {OP_RS, OP_RC, OP_RSI, OP_RCI}) && (opnd != '0));
        bad      = (req_i.op != OP_NONE) &&
                   (!known || (req_i.op == 3'd7) || (!writable && writes));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q   <= 1'b0;
            bad_q  <= 1'b0;
            op_q   <= OP_NONE;
            addr_q <= '0;
            opnd_q <= '0;
            chk_q  <= 1'b0;
            exp_q  <= '0;
        end else begin
            wr_q   <= (req_i.op != OP_NONE) && !bad && writes;
            bad_q  <= bad;
            op_q   <= req_i.op;
            addr_q <= req_i.addr;
            opnd_q <= opnd;
            chk_q  <= wr_q && (req_i.op != OP_NONE) && !bad && (req_i.addr == addr_q);
            // rdata_o here is the old half seen by the writing request
            if (op_q inside {OP_RW, OP_RWI}) begin
                exp_q <= opnd_q;
            end else if (op_q inside {OP_RS, OP_RSI}) begin
                exp_q <= rdata_o | opnd_q;
            end else begin
                exp_q <= rdata_o & ~opnd_q;
            end
        end
    end

    a_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
                              (rdata_o == '0 && !illegal_o))
        else begin
            fail_cnt++;
            $error("FAILED rdata_o %h illegal_o %h, expected 0 around reset", rdata_o, illegal_o);
        end

    a_flag: assert property (@(posedge clk) disable iff (!rst_n)
                             (req_i.op != OP_NONE) |=> (illegal_o == bad_q))
        else begin
            fail_cnt++;
            $error("FAILED illegal_o %h, expected %h", illegal_o, bad_q);
        end

    a_zero: assert property (@(posedge clk) disable iff (!rst_n) illegal_o |-> rdata_o == '0)
        else begin
            fail_cnt++;
            $error("FAILED rdata_o %h, expected 0 on an illegal request", rdata_o);
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                             (req_i.op == OP_NONE) |=> ($stable(rdata_o) && $stable(illegal_o)))
        else begin
            fail_cnt++;
            $error("FAILED rdata_o %h illegal_o %h changed without a request",
                   rdata_o, illegal_o);
        end

    a_rdwr: assert property (@(posedge clk) disable iff (!rst_n) chk_q |-> rdata_o == exp_q)
        else begin
            fail_cnt++;
            $error("FAILED rdata_o %h, expected %h after a write", rdata_o, exp_q);
        end

endmodule

bind csr_unit csr_unit_sva u_sva (.*);

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

    import csr_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 3;
    localparam int N_PULSES    = 40;  // Instret pulse train
    localparam int TIME_K      = 5;   // Time ticks between two reads
    // Reset, write/read, set/clear, instret, time, carry, illegal, end
    localparam int TEST_CYCLES = RST_CYCLES + 3 + 8 + 12 + N_PULSES + 2
                                 + TIME_DIV * TIME_K + 5 + 11 + 2;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 50) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst_n;
    csr_req_t    req;
    logic        retire;
    xlen_t       rdata;
    logic        illegal;

    int          errors    = 0;
    int          since_rst = 0;       // Edges since reset release
    logic [31:0] lfsr      = 32'h8f03;

    csr_unit u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req),
        .retire_i  (retire),
        .rdata_o   (rdata),
        .illegal_o (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (rst_n) since_rst <= since_rst + 1;
    end

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output xlen_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);      // One step per bit
            v    = {v[XLEN-2:0], lfsr[0]};
        end
    endtask

    // Drive at the falling edge, result is stable one falling edge later
    task automatic csr_req(input csr_op_e op, input csr_addr_t addr, input xlen_t wdata,
                           output xlen_t rd);
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        retire    = 1'b0;  // No retire in read cycles
        @(negedge clk);
        rd        = rdata;
        req.op    = OP_NONE;
    endtask

    task automatic check_eq(input string name, input xlen_t got, input xlen_t exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input string what, input logic ok);
        assert (ok) else begin
            errors++;
            $display("Wrong behavior: %s did not hold", what);
        end
    endtask

    initial begin
        xlen_t     v, m, m5, a, b, h, rd;
        int        pulses;
        csr_addr_t waddr [4];
        csr_op_e   ops   [4];

        rst_n  = 1'b1;
        req    = '0;
        retire = 1'b0;
        waddr  = '{ADDR_MCYCLE, ADDR_MCYCLEH, ADDR_MINSTRET, ADDR_MINSTRETH};
        ops    = '{OP_RS, OP_RC, OP_RSI, OP_RCI};
        #1 rst_n = 1'b0;  // Async assert ahead of the first rising edge
        repeat (RST_CYCLES) @(negedge clk);
        rst_n  = 1'b1;

        // Cycle starts from zero at release
        repeat (2) @(negedge clk);
        csr_req(OP_RS, ADDR_CYCLE, '0, rd);
        check_true("first cycle read below edges since release", rd < xlen_t'(since_rst));

        // Write then read back, exact in the next cycle
        foreach (waddr[i]) begin
            rand_bits(XLEN, v);
            csr_req(OP_RW, waddr[i], v, rd);
            csr_req(OP_RS, waddr[i], '0, rd);
            check_eq("rdata_o", rd, v);
        end

        // Set and clear forms, mask kept nonzero so each one writes
        foreach (ops[i]) begin
            rand_bits(XLEN, v);
            rand_bits(XLEN, m);
            m[0] = 1'b1;
            m5   = (ops[i] inside {OP_RSI, OP_RCI}) ? (m & 32'h1f) : m;
            csr_req(OP_RW, waddr[i], v, rd);
            csr_req(ops[i], waddr[i], m, rd);
            check_eq("rdata_o", rd, v);
            csr_req(OP_RS, waddr[i], '0, rd);
            check_eq("rdata_o", rd, (ops[i] inside {OP_RS, OP_RSI}) ? (v | m5) : (v & ~m5));
        end

        // Instret against a random pulse train
        csr_req(OP_RS, ADDR_MINSTRET, '0, a);
        pulses = 0;
        for (int i = 0; i < N_PULSES; i++) begin
            rand_bits(1, v);
            retire = v[0];
            pulses += v[0];
            @(negedge clk);
        end
        csr_req(OP_RS, ADDR_MINSTRET, '0, b);
        check_eq("instret delta", b - a, xlen_t'(pulses));

        // Time, TIME_DIV * TIME_K edges between the two reads
        csr_req(OP_RS, ADDR_TIME, '0, a);
        repeat (TIME_DIV * TIME_K - 1) @(negedge clk);
        csr_req(OP_RS, ADDR_TIME, '0, b);
        check_eq("time delta", b - a, xlen_t'(TIME_K));

        // Carry from mcycle low into mcycleh
        csr_req(OP_RW, ADDR_MCYCLE, '0, rd);
        csr_req(OP_RS, ADDR_MCYCLEH, '0, h);
        csr_req(OP_RW, ADDR_MCYCLE, '1, rd);
        csr_req(OP_RS, ADDR_MCYCLEH, '0, rd);  // Still before the carry edge
        csr_req(OP_RS, ADDR_MCYCLEH, '0, rd);
        check_eq("mcycleh", rd, h + 1);

        // Illegal requests, flag and zero data checked by the bound assertions
        csr_req(OP_RS, 12'h123, '0, rd);
        csr_req(OP_RSI, ADDR_CYCLE, 32'hffff_ffe0, rd);  // zimm is zero, plain read
        csr_req(OP_RS, ADDR_MCYCLE, '0, a);
        rand_bits(XLEN, v);
        csr_req(csr_op_e'(3'd7), ADDR_MCYCLE, v, rd);
        csr_req(OP_RW, ADDR_CYCLE, v, rd);
        check_true("RW to cycle flagged illegal", illegal);
        csr_req(OP_RS, ADDR_MCYCLE, '0, b);
        check_eq("mcycle", b, a + 3);  // Normal counting only
        csr_req(OP_RW, ADDR_TIME, v, rd);
        csr_req(OP_RS, ADDR_INSTRETH, '0, h);
        csr_req(OP_RW, ADDR_INSTRETH, v, rd);
        csr_req(OP_RS, ADDR_INSTRETH, '0, rd);
        check_eq("instreth", rd, h);

        repeat (2) @(negedge clk);
        $display("Error counts: %0d testbench, %0d assertion", errors, u_dut.u_sva.fail_cnt);
        if (errors == 0 && u_dut.u_sva.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Ends a stuck run
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/csr_pkg.sv
verilog/csr_counters.sv
verilog/csr_access.sv
verilog/csr_unit.sv
dv/csr_unit_sva.sv
dv/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - verilog/csr_pkg.sv
      - verilog/csr_counters.sv
      - verilog/csr_access.sv
      - verilog/csr_unit.sv
  - target: test
    files:
      - dv/csr_unit_sva.sv
      - dv/csr_unit_tb.sv
